// ==== Makefile ====
TOP := acl_rx_buf_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src.f ====
src/acl_rx_pkg.sv
src/host_bus_pkg.sv
src/bank_bus_if.sv
src/acl_rx_bank.sv
src/acl_rx_writer.sv
src/acl_rx_host_port.sv
src/acl_rx_buf.sv
tests/acl_rx_buf_props.sv
tests/acl_rx_buf_tb.sv

// ==== src/acl_rx_bank.sv ====
// One payload bank
// Word memory with registered read, committed length and free/full state

`timescale 1ns/100ps

module acl_rx_bank
  import acl_rx_pkg::*;
#(
  parameter int BANK_ID   = 0,
  parameter int NUM_BANKS = 2
) (
  input  logic     clk_6M,
  input  logic     rstz,
  bank_bus_if.bank bus
);

  localparam int BANK_W = bank_w(NUM_BANKS);
  localparam logic [BANK_W-1:0] MY_ID = BANK_W'(BANK_ID);

  logic [31:0]        mem [2**WORD_AW];
  logic [31:0]        rd_q;
  logic [PYLEN_W-1:0] len_q;
  bank_state_t        state;
  logic               wr_sel;
  logic               rd_sel;

  assign wr_sel = (bus.wr_bank == MY_ID);
  assign rd_sel = (bus.rd_bank == MY_ID);

  // Single-port style SRAM model, read data appears the cycle after rd_en
  always_ff @(posedge clk_6M)
  begin
    if (wr_sel && bus.wr_en)
    begin
      mem[bus.wr_addr] <= bus.wr_data;
    end
    if (rd_sel && bus.rd_en)
    begin
      rd_q <= mem[bus.rd_addr];
    end
  end

  // Full on commit from the writer, free again on release from the host
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state <= BANK_FREE;
      len_q <= '0;
    end
    else if (wr_sel && bus.commit)
    begin
      state <= BANK_FULL;
      len_q <= bus.commit_len;
    end
    else if (rd_sel && bus.release_p)
    begin
      state <= BANK_FREE;
    end
  end

  assign bus.full[BANK_ID]    = (state == BANK_FULL);
  assign bus.rd_data[BANK_ID] = rd_q;
  assign bus.length[BANK_ID]  = len_q;

endmodule

// ==== src/acl_rx_buf.sv ====
// ACL receive payload buffer top level
// Writer, payload banks and Wishbone host port

`timescale 1ns/100ps

module acl_rx_buf
  import acl_rx_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int NUM_BANKS = 2
) (
  input  logic               clk_6M,
  input  logic               rstz,
  // Payload decoder
  input  logic [7:0]         pyld_byte,
  input  logic               pyld_valid,
  input  logic               pyld_start,
  // Slot and packet checks
  input  logic               ms_tslot_p,
  input  logic               pk_encode,
  input  logic               dec_hecgood,
  input  logic               dec_crcgood,
  input  logic [PYLEN_W-1:0] dec_pylen_byte,
  // Host bus
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [WB_AW-1:0]   wb_adr,
  input  logic [31:0]        wb_dat_w,
  output logic [31:0]        wb_dat_r,
  output logic               wb_ack
);

  logic overrun;
  logic overrun_clr;

  bank_bus_if #(.NUM_BANKS(NUM_BANKS)) bank_bus ();

  acl_rx_writer #(.NUM_BANKS(NUM_BANKS)) i_writer (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .pyld_byte      (pyld_byte),
    .pyld_valid     (pyld_valid),
    .pyld_start     (pyld_start),
    .ms_tslot_p     (ms_tslot_p),
    .pk_encode      (pk_encode),
    .dec_hecgood    (dec_hecgood),
    .dec_crcgood    (dec_crcgood),
    .dec_pylen_byte (dec_pylen_byte),
    .overrun_clr    (overrun_clr),
    .overrun        (overrun),
    .bus            (bank_bus)
  );

  for (genvar i = 0; i < NUM_BANKS; i++)
  begin : g_bank
    acl_rx_bank #(.BANK_ID(i), .NUM_BANKS(NUM_BANKS)) i_bank (
      .clk_6M (clk_6M),
      .rstz   (rstz),
      .bus    (bank_bus)
    );
  end

  acl_rx_host_port #(.NUM_BANKS(NUM_BANKS)) i_host_port (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .overrun     (overrun),
    .overrun_clr (overrun_clr),
    .bus         (bank_bus)
  );

endmodule

// ==== src/acl_rx_host_port.sv ====
// Wishbone classic slave for the host
// Data window and status reads, control writes, bank release

`timescale 1ns/100ps

module acl_rx_host_port
  import acl_rx_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int NUM_BANKS = 2
) (
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [WB_AW-1:0] wb_adr,
  input  logic [31:0]      wb_dat_w,
  output logic [31:0]      wb_dat_r,
  output logic             wb_ack,
  input  logic             overrun,
  output logic             overrun_clr,
  bank_bus_if.reader       bus
);

  localparam int BANK_W = bank_w(NUM_BANKS);
  localparam logic [BANK_W-1:0] LAST_BANK = BANK_W'(NUM_BANKS - 1);

  reg_sel_t           sel;
  reg_sel_t           sel_q;
  logic               req;
  logic               rd_last;
  logic               discard;
  logic [PYLEN_W-1:0] cur_len;
  logic [WORD_AW-1:0] end_idx;
  logic [31:0]        status;

  always_comb
  begin
    if (!wb_adr[WB_AW-1])
      sel = REG_DATA;
    else if (wb_adr == ADR_STATUS)
      sel = REG_STATUS;
    else if (wb_adr == ADR_CTRL)
      sel = REG_CTRL;
    else
      sel = REG_NONE;
  end

  // New access only while ack is low, so each access gets one ack
  assign req = wb_cyc && wb_stb && !wb_ack;

  assign bus.rd_en   = req && !wb_we && (sel == REG_DATA);
  assign bus.rd_addr = wb_adr[WORD_AW-1:0];

  // Last word index of the bank being read
  assign cur_len = bus.length[bus.rd_bank];
  assign end_idx = (cur_len[1:0] == 2'b00) ? cur_len[PYLEN_W-1:2] - WORD_AW'(1)
                                           : cur_len[PYLEN_W-1:2];

  assign rd_last = !wb_we && (sel == REG_DATA) && (bus.rd_addr >= end_idx);
  assign discard = wb_we && (sel == REG_CTRL) && wb_dat_w[CT_DISCARD];

  always_comb
  begin
    status                     = '0;
    status[ST_EMPTY]           = !bus.full[bus.rd_bank];
    status[ST_OVERRUN]         = overrun;
    status[ST_LEN +: PYLEN_W]  = cur_len;
  end

  always_comb
  begin
    case (sel_q)
      REG_DATA:   wb_dat_r = bus.rd_data[bus.rd_bank];
      REG_STATUS: wb_dat_r = status;
      default:    wb_dat_r = '0;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      wb_ack        <= 1'b0;
      sel_q         <= REG_NONE;
      overrun_clr   <= 1'b0;
      bus.release_p <= 1'b0;
      bus.rd_bank   <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req)
      begin
        sel_q <= sel;
      end
      // Release strobe lines up with ack, only for a bank that holds a packet
      bus.release_p <= req && bus.full[bus.rd_bank] && (rd_last || discard);
      overrun_clr   <= req && wb_we && (sel == REG_CTRL) && wb_dat_w[CT_CLR_OVR];
      if (bus.release_p)
      begin
        bus.rd_bank <= (bus.rd_bank == LAST_BANK) ? '0 : bus.rd_bank + BANK_W'(1);
      end
    end
  end

endmodule

// ==== src/acl_rx_pkg.sv ====
// Baseband-side receive buffer definitions
// Payload length and word address widths, bank state, bank index width

package acl_rx_pkg;

  // Payload length in bytes, up to 1023
  localparam int PYLEN_W = 10;

  // Word address inside one bank, 256 words
  localparam int WORD_AW = 8;

  // Free banks may be filled by the writer, full banks wait for the host
  typedef enum logic {
    BANK_FREE = 1'b0,
    BANK_FULL = 1'b1
  } bank_state_t;

  // Width of a bank index for a given bank count
  function automatic int bank_w(input int num_banks);
    int w;
    begin
      w = 1;
      if (num_banks > 1)
      begin
        w = $clog2(num_banks);
      end
      return w;
    end
  endfunction

endpackage

// ==== src/acl_rx_writer.sv ====
// Receive writer
// Byte to word packing, bank selection, packet commit and overrun detection

`timescale 1ns/100ps

module acl_rx_writer
  import acl_rx_pkg::*;
#(
  parameter int NUM_BANKS = 2
) (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic [7:0]         pyld_byte,
  input  logic               pyld_valid,
  input  logic               pyld_start,
  input  logic               ms_tslot_p,
  input  logic               pk_encode,
  input  logic               dec_hecgood,
  input  logic               dec_crcgood,
  input  logic [PYLEN_W-1:0] dec_pylen_byte,
  input  logic               overrun_clr,
  output logic               overrun,
  bank_bus_if.writer         bus
);

  localparam int BANK_W = bank_w(NUM_BANKS);
  localparam logic [BANK_W-1:0] LAST_BANK = BANK_W'(NUM_BANKS - 1);

  typedef enum logic [1:0] {
    W_IDLE,
    W_RECV,
    W_DROP,
    W_FLUSH
  } wr_state_t;

  wr_state_t          state;
  logic [1:0]         lane;
  logic [1:0]         lane_base;
  logic [31:0]        word;
  logic [WORD_AW-1:0] waddr;
  logic               target_full;
  logic               slot_good;
  logic               accept;

  assign target_full = bus.full[bus.wr_bank];
  assign slot_good   = ms_tslot_p && dec_hecgood && dec_crcgood && !pk_encode;
  // A byte may arrive together with the start strobe
  assign lane_base   = pyld_start ? 2'd0 : lane;
  assign accept      = pyld_valid && (pyld_start ? !target_full : (state == W_RECV));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state       <= W_IDLE;
      lane        <= 2'd0;
      waddr       <= '0;
      overrun     <= 1'b0;
      bus.wr_en   <= 1'b0;
      bus.commit  <= 1'b0;
      bus.wr_bank <= '0;
    end
    else
    begin
      bus.commit <= 1'b0;
      bus.wr_en  <= accept && (lane_base == 2'd3);

      if (pyld_start)
      begin
        state <= target_full ? W_DROP : W_RECV;
      end
      else
      begin
        case (state)
          W_RECV:
            if (ms_tslot_p)
            begin
              state <= W_IDLE;
              if (slot_good && (lane != 2'd0))
              begin
                // Flush the open word first, commit follows next cycle
                state     <= W_FLUSH;
                bus.wr_en <= 1'b1;
              end
              else if (slot_good)
              begin
                bus.commit <= 1'b1;
              end
            end
          W_FLUSH:
          begin
            state      <= W_IDLE;
            bus.commit <= 1'b1;
          end
          W_DROP:
            if (ms_tslot_p)
            begin
              state <= W_IDLE;
            end
          default: ;
        endcase
      end

      if (accept)
      begin
        lane <= lane_base + 2'd1;
      end
      else if (pyld_start || ms_tslot_p)
      begin
        lane <= 2'd0;
      end

      if (pyld_start)
      begin
        waddr <= '0;
      end
      else if (bus.wr_en)
      begin
        waddr <= waddr + WORD_AW'(1);
      end

      if (bus.commit)
      begin
        bus.wr_bank <= (bus.wr_bank == LAST_BANK) ? '0 : bus.wr_bank + BANK_W'(1);
      end

      // Sticky until the host clears it
      if (pyld_start && target_full)
      begin
        overrun <= 1'b1;
      end
      else if (overrun_clr)
      begin
        overrun <= 1'b0;
      end
    end
  end

  // Little-endian packing, unused upper lanes read as zero
  always_ff @(posedge clk_6M)
  begin
    if (accept)
    begin
      if (lane_base == 2'd0)
      begin
        word <= {24'd0, pyld_byte};
      end
      else
      begin
        word[8*lane_base +: 8] <= pyld_byte;
      end
    end
    if ((state == W_RECV) && slot_good && !pyld_start)
    begin
      bus.commit_len <= dec_pylen_byte;
    end
  end

  assign bus.wr_data = word;
  assign bus.wr_addr = waddr;

endmodule

// ==== src/bank_bus_if.sv ====
// Bank bus between the writer, the payload banks and the host reader

`timescale 1ns/100ps

interface bank_bus_if
  import acl_rx_pkg::*;
#(
  parameter int NUM_BANKS = 2
) ();

  localparam int BANK_W = bank_w(NUM_BANKS);

  // Write side
  logic [BANK_W-1:0]  wr_bank;
  logic               wr_en;
  logic [WORD_AW-1:0] wr_addr;
  logic [31:0]        wr_data;
  logic               commit;
  logic [PYLEN_W-1:0] commit_len;

  // One slice per bank, each driven by its own bank
  wire [NUM_BANKS-1:0] full;
  wire [31:0]          rd_data [NUM_BANKS];
  wire [PYLEN_W-1:0]   length [NUM_BANKS];

  // Read side
  logic [BANK_W-1:0]  rd_bank;
  logic               rd_en;
  logic [WORD_AW-1:0] rd_addr;
  logic               release_p;

  modport writer (
    output wr_bank, wr_en, wr_addr, wr_data, commit, commit_len,
    input  full
  );

  modport bank (
    input  wr_bank, wr_en, wr_addr, wr_data, commit, commit_len,
    input  rd_bank, rd_en, rd_addr, release_p,
    output full, rd_data, length
  );

  modport reader (
    output rd_bank, rd_en, rd_addr, release_p,
    input  full, rd_data, length
  );

endinterface

// ==== src/host_bus_pkg.sv ====
// Host bus definitions
// Wishbone address width, register select opcodes, status and control bits

package host_bus_pkg;

  localparam int WB_AW = 10;

  // Register addresses above the data window
  localparam logic [WB_AW-1:0] ADR_STATUS = 10'h200;
  localparam logic [WB_AW-1:0] ADR_CTRL   = 10'h201;

  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,
    REG_STATUS = 2'd1,
    REG_CTRL   = 2'd2,
    REG_NONE   = 2'd3
  } reg_sel_t;

  // Status word, length field starts at ST_LEN
  localparam int ST_EMPTY   = 0;
  localparam int ST_OVERRUN = 1;
  localparam int ST_LEN     = 16;

  // Control word
  localparam int CT_CLR_OVR = 0;
  localparam int CT_DISCARD = 1;

endpackage

// ==== tests/acl_rx_buf_props.sv ====
// Bound assertions for the receive buffer
// Wishbone handshake timing and the overrun flag

`timescale 1ns/100ps

module acl_rx_buf_props
  import host_bus_pkg::*;
(
  input logic             clk_6M,
  input logic             rstz,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_we,
  input logic [WB_AW-1:0] wb_adr,
  input logic             wb_ack,
  input logic             overrun,
  input logic             overrun_clr
);

  // One wait state per access
  a_ack_follows: assert property (@(posedge clk_6M) disable iff (!rstz)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else $error("wb_ack did not follow cyc and stb by one cycle");

  a_ack_single: assert property (@(posedge clk_6M) disable iff (!rstz)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for more than one cycle");

  a_ack_cyc: assert property (@(posedge clk_6M) disable iff (!rstz)
    wb_ack |-> wb_cyc)
    else $error("wb_ack high without wb_cyc");

  a_ack_reset: assert property (@(posedge clk_6M)
    !rstz |-> !wb_ack)
    else $error("wb_ack high during reset");

  // Sticky flag, cleared only through the control register
  a_ovr_clear: assert property (@(posedge clk_6M) disable iff (!rstz)
    $fell(overrun) |-> $past(overrun_clr)
      && $past(wb_cyc && wb_stb && wb_we && (wb_adr == ADR_CTRL), 2))
    else $error("overrun fell without a control write");

endmodule

bind acl_rx_buf acl_rx_buf_props i_props (
  .clk_6M      (clk_6M),
  .rstz        (rstz),
  .wb_cyc      (wb_cyc),
  .wb_stb      (wb_stb),
  .wb_we       (wb_we),
  .wb_adr      (wb_adr),
  .wb_ack      (wb_ack),
  .overrun     (overrun),
  .overrun_clr (overrun_clr)
);

// ==== tests/acl_rx_buf_tb.sv ====
// Testbench for the ACL receive payload buffer
// LCG stimulus, Wishbone bus tasks, packet model, watchdog and summary

`timescale 1ns/100ps

module acl_rx_buf_tb
  import acl_rx_pkg::*;
  import host_bus_pkg::*;
;

  localparam int NUM_BANKS  = 2;
  localparam int CLK_PERIOD = 100;
  localparam int MAX_LEN    = 339;
  localparam int N_PACKETS  = 13;
  localparam int ACK_LIMIT  = 16;
  localparam int WATCHDOG_CYCLES = N_PACKETS * (MAX_LEN + 300);

  logic               clk_6M;
  logic               rstz;
  logic [7:0]         pyld_byte;
  logic               pyld_valid;
  logic               pyld_start;
  logic               ms_tslot_p;
  logic               pk_encode;
  logic               dec_hecgood;
  logic               dec_crcgood;
  logic [PYLEN_W-1:0] dec_pylen_byte;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [WB_AW-1:0]   wb_adr;
  logic [31:0]        wb_dat_w;
  logic [31:0]        wb_dat_r;
  logic               wb_ack;

  logic [31:0] rng = 32'hee13;
  int          errors = 0;
  int          checks = 0;
  logic        ovr_model = 1'b0;
  // Committed packets in arrival order, bytes kept flat
  int          model_len[$];
  logic [7:0]  model_bytes[$];
  logic [31:0] rd;

  acl_rx_buf #(.NUM_BANKS(NUM_BANKS)) i_dut (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .pyld_byte      (pyld_byte),
    .pyld_valid     (pyld_valid),
    .pyld_start     (pyld_start),
    .ms_tslot_p     (ms_tslot_p),
    .pk_encode      (pk_encode),
    .dec_hecgood    (dec_hecgood),
    .dec_crcgood    (dec_crcgood),
    .dec_pylen_byte (dec_pylen_byte),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack)
  );

  initial
  begin
    clk_6M = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk_6M = ~clk_6M;

  function automatic logic [31:0] rand32();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic int rand_len();
    logic [31:0] r;
    r = rand32();
    return 1 + int'(r % 32'(MAX_LEN));
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // Called just after a falling edge, returns just after one
  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waits;
    waits    = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do
    begin
      @(negedge clk_6M);
      waits++;
    end while (!wb_ack && (waits < ACK_LIMIT));
    if (!wb_ack)
    begin
      $display("No acknowledge from the host port for address %h", adr);
      errors++;
    end
    else
    begin
      check_value("wb_ack latency", 32'd1, 32'(waits));
    end
    rdat = wb_dat_r;
    // Hold the request until the slave has sampled ack
    @(negedge clk_6M);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic check_status();
    logic [31:0] st;
    wb_read(ADR_STATUS, st);
    check_value("status empty", 32'(model_len.size() == 0), 32'(st[ST_EMPTY]));
    check_value("status overrun", 32'(ovr_model), 32'(st[ST_OVERRUN]));
    if (model_len.size() != 0)
    begin
      check_value("status length", 32'(model_len[0]), 32'(st[ST_LEN +: PYLEN_W]));
    end
  endtask

  task automatic send_packet(input int len, input logic hec, input logic crc, input logic enc);
    logic [31:0] r;
    logic        dropped;
    logic        kept;
    int          i;
    // Writer target bank is full only when every bank holds a packet
    dropped    = (model_len.size() == NUM_BANKS);
    kept       = !dropped && hec && crc && !enc;
    pyld_start = 1'b1;
    @(negedge clk_6M);
    pyld_start = 1'b0;
    for (i = 0; i < len; i++)
    begin
      r          = rand32();
      pyld_valid = 1'b1;
      pyld_byte  = r[15:8];
      if (kept)
      begin
        model_bytes.push_back(r[15:8]);
      end
      @(negedge clk_6M);
    end
    pyld_valid     = 1'b0;
    ms_tslot_p     = 1'b1;
    dec_hecgood    = hec;
    dec_crcgood    = crc;
    pk_encode      = enc;
    dec_pylen_byte = PYLEN_W'(len);
    @(negedge clk_6M);
    ms_tslot_p  = 1'b0;
    dec_hecgood = 1'b0;
    dec_crcgood = 1'b0;
    pk_encode   = 1'b0;
    // Flush and commit land within two cycles of the slot strobe
    repeat (3) @(negedge clk_6M);
    if (dropped)
    begin
      ovr_model = 1'b1;
    end
    if (kept)
    begin
      model_len.push_back(len);
    end
  endtask

  task automatic read_packet();
    int          len;
    int          w;
    int          b;
    logic [31:0] exp;
    logic [31:0] got;
    check_status();
    len = model_len.pop_front();
    for (w = 0; w < (len + 3) / 4; w++)
    begin
      exp = '0;
      for (b = 0; b < 4; b++)
      begin
        if (4 * w + b < len)
        begin
          exp[8*b +: 8] = model_bytes.pop_front();
        end
      end
      wb_read(WB_AW'(w), got);
      check_value($sformatf("wb_dat_r word %0d", w), exp, got);
    end
    check_status();
  endtask

  task automatic discard_packet();
    int len;
    int i;
    wb_write(ADR_CTRL, 32'd1 << CT_DISCARD);
    len = model_len.pop_front();
    for (i = 0; i < len; i++)
    begin
      void'(model_bytes.pop_front());
    end
    check_status();
  endtask

  task automatic clear_overrun();
    wb_write(ADR_CTRL, 32'd1 << CT_CLR_OVR);
    ovr_model = 1'b0;
    check_status();
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    rstz           = 1'b0;
    pyld_byte      = '0;
    pyld_valid     = 1'b0;
    pyld_start     = 1'b0;
    ms_tslot_p     = 1'b0;
    pk_encode      = 1'b0;
    dec_hecgood    = 1'b0;
    dec_crcgood    = 1'b0;
    dec_pylen_byte = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    // Three rising edges with reset low
    repeat (3) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
    @(negedge clk_6M);

    // Reset state and an unmapped address
    check_status();
    wb_read(10'h3ff, rd);
    check_value("wb_dat_r unmapped", 32'd0, rd);

    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    read_packet();

    // Rejected packets, then a good one
    send_packet(rand_len(), 1'b0, 1'b1, 1'b0);
    check_status();
    send_packet(rand_len(), 1'b1, 1'b0, 1'b0);
    check_status();
    send_packet(rand_len(), 1'b1, 1'b1, 1'b1);
    check_status();
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    read_packet();

    // Back to back, second one ends on a word boundary
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    send_packet(256, 1'b1, 1'b1, 1'b0);
    read_packet();
    read_packet();

    // Both banks full, third packet is dropped
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    check_status();
    clear_overrun();
    read_packet();
    read_packet();

    // Discard without reading
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    discard_packet();
    read_packet();
    send_packet(rand_len(), 1'b1, 1'b1, 1'b0);
    discard_packet();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
